/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN        = 32;                     // Data and instruction width
    localparam int REG_ADDR_W  = 5;                      // 32 architectural registers
    localparam int IMEM_DEPTH  = 256;                    // Instruction words
    localparam int IMEM_ADDR_W = $clog2(IMEM_DEPTH);     // Word address into instruction memory

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,                              // R-type, operation in funct
        OP_ADDI    = 6'h08,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_HALT    = 6'h3F                               // Stops fetch, latches halt at top
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT                                          // Signed set-less-than
    } alu_op_e;

    typedef struct packed {
        logic            valid;                          // Low for a bubble
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       op_a;                     // rs value read in decode
        logic [XLEN-1:0]       op_b;                     // rt value read in decode
        logic [XLEN-1:0]       imm;                      // Already sign or zero extended
        logic                  alu_src;                  // 1 selects imm for operand B
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;                       // Destination, rd or rt by type
        logic                  reg_write;
        logic                  halt;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  halt;
    } ex_wb_t;

endpackage

/* logic/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem (
    input  logic                            i_clk,
    // Debug loader side
    input  logic                            i_wr_en,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] i_wr_addr,
    input  logic [cpu_pkg::XLEN-1:0]        i_wr_data,
    // Fetch side
    input  logic                            i_rd_en,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] i_rd_addr,
    output logic [cpu_pkg::XLEN-1:0]        o_rd_data,
    output logic                            o_fetch_grant
);
    import cpu_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];                   // Program storage, survives reset

    // Debug write always wins, fetch waits one cycle
    assign o_fetch_grant = i_rd_en & ~i_wr_en;

    // Asynchronous read, zero word when fetch is not granted
    assign o_rd_data = o_fetch_grant ? mem[i_rd_addr] : '0;

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;                 // Loader write, independent of clk_en
        end
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_clk_en,
    input  logic                            i_halt_seen,  // HALT sitting in decode
    input  logic                            i_grant,      // Memory granted this read
    input  logic [cpu_pkg::XLEN-1:0]        i_instr,
    output logic                            o_rd_en,
    output logic [cpu_pkg::IMEM_ADDR_W-1:0] o_pc_addr,
    output cpu_pkg::if_id_t                 o_if_id
);
    import cpu_pkg::*;

    logic [IMEM_ADDR_W-1:0] pc_q;                        // Word address of next fetch
    logic                   halted_q;                    // Sticky once HALT was decoded
    logic                   halt_active;
    logic                   fetch_ok;

    // HALT leaves decode after one cycle, so keep it sticky here
    assign halt_active = i_halt_seen | halted_q;
    assign o_rd_en     = ~halt_active;                   // Stop requesting after HALT
    assign o_pc_addr   = pc_q;
    assign fetch_ok    = i_grant & ~halt_active;         // Real instruction this cycle

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q          <= '0;
            halted_q      <= 1'b0;
            o_if_id.valid <= 1'b0;
        end else if (i_clk_en) begin
            if (i_halt_seen) begin
                halted_q <= 1'b1;
            end
            if (fetch_ok) begin
                pc_q <= pc_q + 1'b1;                     // Hold PC on lost grant
            end
            o_if_id.valid <= fetch_ok;                   // Bubble when denied or halted
            o_if_id.instr <= i_instr;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_clk_en,
    input  cpu_pkg::if_id_t                i_if_id,
    input  cpu_pkg::ex_wb_t                i_ex_wb,       // Writeback into register file
    input  logic [cpu_pkg::REG_ADDR_W-1:0] i_du_reg_addr,
    output logic [cpu_pkg::XLEN-1:0]       o_du_reg_data,
    output logic                           o_halt_seen,
    output cpu_pkg::id_ex_t                o_id_ex
);
    import cpu_pkg::*;

    logic [XLEN-1:0]       regs [2**REG_ADDR_W];        // No reset, r0 masked on read
    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [15:0]           imm16;
    logic                  wb_en;
    alu_op_e               alu_op;
    logic                  alu_src;
    logic                  reg_write;
    logic                  is_halt;
    logic                  zero_ext;                     // ANDI and ORI zero extend
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       imm_ext;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;

    // Instruction fields
    assign opcode   = opcode_e'(i_if_id.instr[31:26]);
    assign funct    = funct_e'(i_if_id.instr[5:0]);
    assign rs       = i_if_id.instr[25:21];
    assign rt       = i_if_id.instr[20:16];
    assign rd_field = i_if_id.instr[15:11];
    assign imm16    = i_if_id.instr[15:0];

    // Writeback port, r0 is never written
    assign wb_en = i_ex_wb.valid & i_ex_wb.reg_write & (i_ex_wb.rd != '0);

    always_ff @(posedge i_clk) begin
        if (i_clk_en && wb_en) begin
            regs[i_ex_wb.rd] <= i_ex_wb.result;
        end
    end

    // Write-first reads, same-cycle writeback is bypassed
    assign rs_data = (rs == '0) ? '0 :
                     (wb_en && i_ex_wb.rd == rs) ? i_ex_wb.result : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wb_en && i_ex_wb.rd == rt) ? i_ex_wb.result : regs[rt];
    assign o_du_reg_data = (i_du_reg_addr == '0) ? '0 :
                           (wb_en && i_ex_wb.rd == i_du_reg_addr) ? i_ex_wb.result
                                                                  : regs[i_du_reg_addr];

    always_comb begin
        alu_op    = ALU_ADD;                             // Defaults give a no-op
        alu_src   = 1'b0;
        reg_write = 1'b0;
        is_halt   = 1'b0;
        zero_ext  = 1'b0;
        dest      = rd_field;
        if (i_if_id.valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    reg_write = 1'b1;
                    case (funct)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        default: reg_write = 1'b0;       // Unknown funct, nothing written
                    endcase
                end
                OP_ADDI: begin
                    alu_src   = 1'b1;
                    reg_write = 1'b1;
                    dest      = rt;                      // I-type writes rt
                end
                OP_ANDI: begin
                    alu_op    = ALU_AND;
                    alu_src   = 1'b1;
                    zero_ext  = 1'b1;
                    reg_write = 1'b1;
                    dest      = rt;
                end
                OP_ORI: begin
                    alu_op    = ALU_OR;
                    alu_src   = 1'b1;
                    zero_ext  = 1'b1;
                    reg_write = 1'b1;
                    dest      = rt;
                end
                OP_HALT: is_halt = 1'b1;
                default: ;                               // Unknown opcode, no-op
            endcase
        end
    end

    assign imm_ext = zero_ext ? {{(XLEN-16){1'b0}}, imm16} : {{(XLEN-16){imm16[15]}}, imm16};
    assign o_halt_seen = is_halt;                        // Freezes fetch

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex.valid     <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
            o_id_ex.halt      <= 1'b0;
        end else if (i_clk_en) begin
            o_id_ex.valid     <= i_if_id.valid;
            o_id_ex.op_a      <= rs_data;
            o_id_ex.op_b      <= rt_data;
            o_id_ex.imm       <= imm_ext;
            o_id_ex.alu_src   <= alu_src;
            o_id_ex.alu_op    <= alu_op;
            o_id_ex.rs        <= rs;
            o_id_ex.rt        <= rt;
            o_id_ex.rd        <= dest;
            o_id_ex.reg_write <= reg_write;
            o_id_ex.halt      <= is_halt;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_clk_en,
    input  cpu_pkg::id_ex_t i_id_ex,
    output cpu_pkg::ex_wb_t o_ex_wb
);
    import cpu_pkg::*;

    logic            fwd_ok;                             // Previous result is a register write
    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    // Forward from own output register, r0 never forwarded
    assign fwd_ok = o_ex_wb.valid & o_ex_wb.reg_write & (o_ex_wb.rd != '0);
    assign fwd_a  = fwd_ok & (o_ex_wb.rd == i_id_ex.rs);
    assign fwd_b  = fwd_ok & (o_ex_wb.rd == i_id_ex.rt);

    assign op_a   = fwd_a ? o_ex_wb.result : i_id_ex.op_a;
    assign rt_val = fwd_b ? o_ex_wb.result : i_id_ex.op_b;
    assign op_b   = i_id_ex.alu_src ? i_id_ex.imm : rt_val;   // Immediate for I-type

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;           // Wraps, no overflow trap
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_wb.valid     <= 1'b0;
            o_ex_wb.reg_write <= 1'b0;
            o_ex_wb.halt      <= 1'b0;
        end else if (i_clk_en) begin
            o_ex_wb.valid     <= i_id_ex.valid;
            o_ex_wb.result    <= alu_result;
            o_ex_wb.rd        <= i_id_ex.rd;
            o_ex_wb.reg_write <= i_id_ex.valid & i_id_ex.reg_write;
            o_ex_wb.halt      <= i_id_ex.valid & i_id_ex.halt;   // Carried to top latch
        end
    end

endmodule

/* logic/mips_pipeline.sv */
`timescale 1ns/1ps

module mips_pipeline (
    input  logic                            i_clk,
    input  logic                            i_clk_en,           // Global pipeline enable
    input  logic                            i_reset,
    input  logic [cpu_pkg::XLEN-1:0]        i_du_data,          // Loader instruction word
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] i_du_inst_addr_wr,
    input  logic                            i_du_write_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]  i_du_reg_addr,
    output logic                            o_du_halt,
    output logic [cpu_pkg::XLEN-1:0]        o_du_reg_data
);
    import cpu_pkg::*;

    if_id_t                 if_id;
    id_ex_t                 id_ex;
    ex_wb_t                 ex_wb;
    logic                   halt_q;                      // Set after HALT leaves writeback
    logic                   stage_en;
    logic                   rd_en;
    logic                   fetch_grant;
    logic                   halt_seen;
    logic [IMEM_ADDR_W-1:0] pc_addr;
    logic [XLEN-1:0]        instr;

    assign stage_en = i_clk_en & ~halt_q;               // Freeze everything once halted

    instr_mem imem_i (
        .i_clk         (i_clk),
        .i_wr_en       (i_du_write_en),
        .i_wr_addr     (i_du_inst_addr_wr),
        .i_wr_data     (i_du_data),
        .i_rd_en       (rd_en),
        .i_rd_addr     (pc_addr),
        .o_rd_data     (instr),
        .o_fetch_grant (fetch_grant)
    );

    fetch_stage fetch_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clk_en    (stage_en),
        .i_halt_seen (halt_seen),
        .i_grant     (fetch_grant),
        .i_instr     (instr),
        .o_rd_en     (rd_en),
        .o_pc_addr   (pc_addr),
        .o_if_id     (if_id)
    );

    decode_stage decode_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clk_en      (stage_en),
        .i_if_id       (if_id),
        .i_ex_wb       (ex_wb),                          // Writeback path
        .i_du_reg_addr (i_du_reg_addr),
        .o_du_reg_data (o_du_reg_data),
        .o_halt_seen   (halt_seen),
        .o_id_ex       (id_ex)
    );

    execute_stage execute_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clk_en (stage_en),
        .i_id_ex  (id_ex),
        .o_ex_wb  (ex_wb)
    );

    // HALT in writeback sets the latch at the end of that cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            halt_q <= 1'b0;
        end else if (stage_en && ex_wb.valid && ex_wb.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign o_du_halt = halt_q;

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk;                          // Half of the 100 ns period
        end
    end

endmodule

/* tests/mips_pipeline_tb.sv */
`timescale 1ns/1ps

module mips_pipeline_tb;
    import cpu_pkg::*;

    localparam int         TIMEOUT_CYCLES = 600;         // Cycle budget of each wait
    localparam int         HOLD_CYCLES    = 20;          // Halt must stay up this long
    localparam logic [5:0] OPC_RTYPE      = 6'h00;       // Standard MIPS encodings
    localparam logic [5:0] OPC_ADDI       = 6'h08;
    localparam logic [5:0] OPC_ANDI       = 6'h0C;
    localparam logic [5:0] OPC_ORI        = 6'h0D;
    localparam logic [5:0] OPC_HALT       = 6'h3F;

    logic                   clk;
    logic                   clk_en;
    logic                   reset;
    logic [XLEN-1:0]        du_data;
    logic [IMEM_ADDR_W-1:0] du_addr;
    logic                   du_write_en;
    logic [REG_ADDR_W-1:0]  du_reg_addr;
    logic                   du_halt;
    logic [XLEN-1:0]        du_reg_data;

    integer          seed;
    int              errors;
    int              checks;
    bit              timed_out;
    logic [31:0]     prog [64];                          // Current program image
    int              prog_len;                           // Including the final HALT
    logic [XLEN-1:0] model_regs [8];                     // Only r0..r7 are ever used

    clock_gen clk_i (.o_clk(clk));

    mips_pipeline dut_i (
        .i_clk             (clk),
        .i_clk_en          (clk_en),
        .i_reset           (reset),
        .i_du_data         (du_data),
        .i_du_inst_addr_wr (du_addr),
        .i_du_write_en     (du_write_en),
        .i_du_reg_addr     (du_reg_addr),
        .o_du_halt         (du_halt),
        .o_du_reg_data     (du_reg_data)
    );

    // Random ALU program over r0..r7 whose first word targets r0
    task automatic make_program();
        int          i;
        int          n;
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  fn;
        logic [5:0]  op;
        n = 20 + int'($unsigned($random(seed)) % 21);
        for (i = 0; i < n; i++) begin
            rs   = 5'($unsigned($random(seed)) % 8);
            rt   = 5'($unsigned($random(seed)) % 8);
            rd   = 5'($unsigned($random(seed)) % 8);
            imm  = 16'($random(seed));
            kind = int'($unsigned($random(seed)) % 9);
            case (kind)
                0:       fn = 6'h21;                     // ADDU
                1:       fn = 6'h23;                     // SUBU
                2:       fn = 6'h24;                     // AND
                3:       fn = 6'h25;                     // OR
                4:       fn = 6'h26;                     // XOR
                default: fn = 6'h2A;                     // SLT
            endcase
            op = (kind == 6) ? OPC_ADDI : (kind == 7) ? OPC_ANDI : OPC_ORI;
            if (i == 0) begin
                prog[i[5:0]] = {OPC_ADDI, rs, 5'd0, imm};
            end else if (kind < 6) begin
                prog[i[5:0]] = {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
            end else begin
                prog[i[5:0]] = {op, rs, rt, imm};
            end
        end
        prog[n[5:0]] = {OPC_HALT, 26'd0};
        prog_len     = n + 1;
    endtask

    // In-order execution of the program on model_regs
    task automatic run_model();
        int          pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        for (pc = 0; pc < prog_len; pc++) begin
            ins   = prog[pc[5:0]];
            a     = model_regs[ins[23:21]];              // rs field stays below 8
            b     = model_regs[ins[18:16]];              // rt
            imm_s = {{16{ins[15]}}, ins[15:0]};
            imm_z = {16'd0, ins[15:0]};
            wr    = 1'b1;
            dst   = ins[20:16];
            res   = '0;
            case (ins[31:26])
                OPC_RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        default: res = {31'd0, $signed(a) < $signed(b)};
                    endcase
                end
                OPC_ADDI: res = a + imm_s;
                OPC_ANDI: res = a & imm_z;
                OPC_ORI:  res = a | imm_z;
                default:  wr = 1'b0;                     // HALT
            endcase
            if (wr && dst != 5'd0) begin
                model_regs[dst[2:0]] = res;
            end
        end
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < prog_len; i++) begin
            @(posedge clk);
            du_write_en <= 1'b1;
            du_addr     <= IMEM_ADDR_W'(i);
            du_data     <= prog[i[5:0]];
        end
        @(posedge clk);
        du_write_en <= 1'b0;
    endtask

    // Combinational debug read sampled mid cycle
    task automatic read_reg(input int idx, output logic [XLEN-1:0] val);
        @(posedge clk);
        du_reg_addr <= REG_ADDR_W'(idx);
        @(negedge clk);
        val = du_reg_data;
    endtask

    task automatic wait_for_halt(input bit random_en);
        int cycles;
        cycles = 0;
        while (!du_halt && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            if (random_en) begin
                clk_en <= ($unsigned($random(seed)) % 100) >= 30;   // About 30% stalled
            end
            @(negedge clk);
            cycles++;
        end
        if (!du_halt) begin
            $display("ERROR: o_du_halt did not rise within %0d cycles", TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_program(input int num, input bit random_en);
        logic [XLEN-1:0] val;
        int              r;
        make_program();
        @(posedge clk);
        reset  <= 1'b1;
        clk_en <= 1'b0;
        load_program();                                  // Overwrites any older program
        repeat (3) @(posedge clk);
        model_regs[0] = '0;
        if (num == 1) begin
            for (r = 1; r < 8; r++) begin
                read_reg(r, val);                        // Power-up contents are unknown
                model_regs[r[2:0]] = val;
            end
        end
        run_model();
        @(posedge clk);
        reset  <= 1'b0;
        clk_en <= 1'b1;
        @(negedge clk);
        checks++;
        if (du_halt !== 1'b0) begin
            $display("MISMATCH at %0t: program %0d o_du_halt high after reset", $time, num);
            errors++;
        end
        wait_for_halt(random_en);
        if (!timed_out) begin
            for (r = 0; r < HOLD_CYCLES; r++) begin
                @(negedge clk);
                checks++;
                if (du_halt !== 1'b1) begin
                    $display("MISMATCH at %0t: program %0d o_du_halt dropped", $time, num);
                    errors++;
                end
            end
            for (r = 0; r < 8; r++) begin
                read_reg(r, val);
                checks++;
                if (val !== model_regs[r[2:0]]) begin
                    $display("MISMATCH at %0t: program %0d r%0d is %h, expected %h",
                             $time, num, r, val, model_regs[r[2:0]]);
                    errors++;
                end
                model_regs[r[2:0]] = val;                // Next program starts from here
            end
        end
    endtask

    initial begin
        seed        = 32'h745f8571;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        clk_en      = 1'b0;
        reset       = 1'b1;
        du_data     = '0;
        du_addr     = '0;
        du_write_en = 1'b0;
        du_reg_addr = '0;
        run_program(1, 1'b0);
        if (!timed_out) begin
            run_program(2, 1'b1);                        // Random clock enable gaps
        end
        if (!timed_out) begin
            run_program(3, 1'b0);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* mips_pipeline.f */
logic/cpu_pkg.sv
logic/instr_mem.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mips_pipeline.sv
tests/clock_gen.sv
tests/mips_pipeline_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module mips_pipeline_tb -f mips_pipeline.f

output="$(./obj_dir/Vmips_pipeline_tb)"
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
